// ==== design/fir_pkg.sv ====
package fir_pkg;

  //--------------------------------------------------------------------------
  // Datapath sizes
  //--------------------------------------------------------------------------

  // One real sample, half of an I/Q word
  localparam int SAMPLE_W  = 16;
  localparam int COEFF_W   = 16;
  localparam int NUM_TAPS  = 8;
  // Full product of sample and coefficient
  localparam int PROD_W    = SAMPLE_W + COEFF_W;
  // Product width plus log2(NUM_TAPS) growth bits
  localparam int ACC_W     = 35;
  // Q15 coefficients, so drop 15 fraction bits
  localparam int OUT_SHIFT = 15;

  // Largest positive coefficient, unity gain in Q15
  localparam logic signed [COEFF_W-1:0] COEFF_UNITY = {1'b0, {(COEFF_W-1){1'b1}}};

  //--------------------------------------------------------------------------
  // Control port map
  //--------------------------------------------------------------------------

  localparam int CTRL_ADDR_W  = 20;
  localparam int CTRL_DATA_W  = 32;
  // Low bits pick the register, the rest pick the block
  localparam int REG_ADDR_W   = 4;
  localparam int BLOCK_ADDR_W = CTRL_ADDR_W - REG_ADDR_W;
  localparam logic [CTRL_ADDR_W-1:0] FIR_BASE_ADDR = 20'h00004;

  // Byte offsets within the block
  typedef enum logic [REG_ADDR_W-1:0] {
    REG_NUM_TAPS        = 4'd0,
    REG_LOAD_COEFF      = 4'd4,
    REG_LOAD_COEFF_LAST = 4'd8
  } fir_reg_e;

  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [CTRL_ADDR_W-1:0] addr;
    logic [CTRL_DATA_W-1:0] data;
  } ctrl_req_t;

  typedef struct packed {
    logic                   ack;
    logic [CTRL_DATA_W-1:0] data;
  } ctrl_resp_t;

  // I in the upper half, Q in the lower half
  typedef struct packed {
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } iq_sample_t;

  // Coefficient reload stream entry
  typedef struct packed {
    logic [COEFF_W-1:0] data;
    logic               last;
  } coeff_reload_t;

endpackage

// ==== design/fir_ctrl_regs.sv ====
`timescale 1ns/1ps

module fir_ctrl_regs
  import fir_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  ctrl_req_t     ctrl_req,
  output ctrl_resp_t    ctrl_resp,
  output coeff_reload_t reload,
  output logic          reload_valid,
  input  logic          reload_ready
);

  //--------------------------------------------------------------------------
  // Address decode
  //--------------------------------------------------------------------------

  logic [BLOCK_ADDR_W-1:0] block_addr;
  fir_reg_e                reg_addr;
  logic                    block_hit;
  logic                    wr_hit;
  logic                    rd_hit;

  // Byte lane bits are dropped from the register offset
  assign block_addr = ctrl_req.addr[CTRL_ADDR_W-1:REG_ADDR_W];
  assign reg_addr   = fir_reg_e'({ctrl_req.addr[REG_ADDR_W-1:2], 2'b00});
  assign block_hit  = (block_addr == FIR_BASE_ADDR[BLOCK_ADDR_W-1:0]);
  assign wr_hit     = ctrl_req.wr && block_hit;
  assign rd_hit     = ctrl_req.rd && block_hit;

  //--------------------------------------------------------------------------
  // Response and reload control
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_resp    <= '0;
      reload_valid <= 1'b0;
    end else begin
      // Ack is a single-cycle pulse
      ctrl_resp.ack  <= 1'b0;
      ctrl_resp.data <= '0;

      // Write completes once both channels took the entry
      if (reload_valid && reload_ready) begin
        reload_valid  <= 1'b0;
        ctrl_resp.ack <= 1'b1;
      end

      // Either load register starts a reload entry
      if (wr_hit) begin
        if (reg_addr == REG_LOAD_COEFF || reg_addr == REG_LOAD_COEFF_LAST) begin
          reload_valid <= 1'b1;
        end
      end

      // Only the tap count is readable
      if (rd_hit && reg_addr == REG_NUM_TAPS) begin
        ctrl_resp.ack  <= 1'b1;
        ctrl_resp.data <= CTRL_DATA_W'(NUM_TAPS);
      end
    end
  end

  // Reload payload, held until accepted
  always_ff @(posedge clk) begin
    if (wr_hit) begin
      case (reg_addr)
        REG_LOAD_COEFF: begin
          reload.data <= ctrl_req.data[COEFF_W-1:0];
          reload.last <= 1'b0;
        end
        REG_LOAD_COEFF_LAST: begin
          reload.data <= ctrl_req.data[COEFF_W-1:0];
          reload.last <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== design/fir_coeff_bank.sv ====
`timescale 1ns/1ps

module fir_coeff_bank
  import fir_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  coeff_reload_t             reload,
  input  logic                      reload_valid,
  output logic                      reload_ready,
  output logic signed [COEFF_W-1:0] coeffs [NUM_TAPS]
);

  logic signed [COEFF_W-1:0] shadow [NUM_TAPS];
  logic                      commit_pending;
  logic                      reload_accept;

  // Stall the stream while the set is copied
  assign reload_ready  = !commit_pending;
  assign reload_accept = reload_valid && reload_ready;

  //--------------------------------------------------------------------------
  // Shadow set and commit
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_pending <= 1'b0;
      // Impulse response after reset
      for (int k = 0; k < NUM_TAPS; k++) begin
        shadow[k] <= (k == 0) ? COEFF_UNITY : '0;
        coeffs[k] <= (k == 0) ? COEFF_UNITY : '0;
      end
    end else begin
      if (reload_accept) begin
        // Newest entry enters at the top, oldest ends at tap 0
        for (int k = 0; k < NUM_TAPS - 1; k++) begin
          shadow[k] <= shadow[k+1];
        end
        shadow[NUM_TAPS-1] <= reload.data;
        commit_pending     <= reload.last;
      end

      // One cycle after the last entry
      if (commit_pending) begin
        coeffs         <= shadow;
        commit_pending <= 1'b0;
      end
    end
  end

endmodule

// ==== design/fir_channel.sv ====
`timescale 1ns/1ps

module fir_channel
  import fir_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic signed [SAMPLE_W-1:0] s_sample,
  input  logic                       s_last,
  input  logic                       s_valid,
  output logic                       s_ready,
  output logic signed [SAMPLE_W-1:0] m_sample,
  output logic                       m_last,
  output logic                       m_valid,
  input  logic                       m_ready,
  input  coeff_reload_t              reload,
  input  logic                       reload_valid,
  output logic                       reload_ready
);

  logic signed [COEFF_W-1:0]  coeffs    [NUM_TAPS];
  logic signed [SAMPLE_W-1:0] taps      [NUM_TAPS];
  logic signed [SAMPLE_W-1:0] next_taps [NUM_TAPS];
  logic signed [PROD_W-1:0]   prods     [NUM_TAPS];
  logic signed [ACC_W-1:0]    acc;
  logic signed [ACC_W-1:0]    acc_scaled;
  logic                       s_accept;

  // Active coefficient set with its shadow
  fir_coeff_bank coeff_bank_inst (
    .clk          (clk),
    .rst          (rst),
    .reload       (reload),
    .reload_valid (reload_valid),
    .reload_ready (reload_ready),
    .coeffs       (coeffs)
  );

  // Room when output is empty or drains this cycle
  assign s_ready  = !m_valid || m_ready;
  assign s_accept = s_valid && s_ready;

  //--------------------------------------------------------------------------
  // Sum of products
  //--------------------------------------------------------------------------

  // Delay line as it will look after this sample shifts in
  always_comb begin
    next_taps[0] = s_sample;
    for (int k = 1; k < NUM_TAPS; k++) begin
      next_taps[k] = taps[k-1];
    end
  end

  always_comb begin
    acc = '0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      prods[k] = coeffs[k] * next_taps[k];
      // Sign extends into the wider accumulator
      acc      = acc + prods[k];
    end
  end

  // Arithmetic shift, low bits kept so large sums wrap
  assign acc_scaled = acc >>> OUT_SHIFT;

  //--------------------------------------------------------------------------
  // Delay line and output register
  //--------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid <= 1'b0;
      for (int k = 0; k < NUM_TAPS; k++) begin
        taps[k] <= '0;
      end
    end else if (s_accept) begin
      taps    <= next_taps;
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  // Payload held steady under back-pressure
  always_ff @(posedge clk) begin
    if (s_accept) begin
      m_sample <= acc_scaled[SAMPLE_W-1:0];
      m_last   <= s_last;
    end
  end

endmodule

// ==== design/fir_iq_core.sv ====
`timescale 1ns/1ps

module fir_iq_core
  import fir_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  ctrl_req_t  ctrl_req,
  output ctrl_resp_t ctrl_resp,
  input  iq_sample_t s_data,
  input  logic       s_last,
  input  logic       s_valid,
  output logic       s_ready,
  output iq_sample_t m_data,
  output logic       m_last,
  output logic       m_valid,
  input  logic       m_ready
);

  coeff_reload_t reload;
  logic          reload_valid;
  logic          reload_ready;

  //--------------------------------------------------------------------------
  // Register block
  //--------------------------------------------------------------------------

  fir_ctrl_regs ctrl_regs_inst (
    .clk          (clk),
    .rst          (rst),
    .ctrl_req     (ctrl_req),
    .ctrl_resp    (ctrl_resp),
    .reload       (reload),
    .reload_valid (reload_valid),
    .reload_ready (reload_ready)
  );

  //--------------------------------------------------------------------------
  // I and Q channels
  //--------------------------------------------------------------------------

  // I channel owns the handshakes
  fir_channel chan_i (
    .clk          (clk),
    .rst          (rst),
    .s_sample     (s_data.i),
    .s_last       (s_last),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .m_sample     (m_data.i),
    .m_last       (m_last),
    .m_valid      (m_valid),
    .m_ready      (m_ready),
    .reload       (reload),
    .reload_valid (reload_valid),
    .reload_ready (reload_ready)
  );

  // Q runs in lockstep, its flow outputs mirror chan_i
  fir_channel chan_q (
    .clk          (clk),
    .rst          (rst),
    .s_sample     (s_data.q),
    .s_last       (s_last),
    .s_valid      (s_valid),
    .s_ready      (),
    .m_sample     (m_data.q),
    .m_last       (),
    .m_valid      (),
    .m_ready      (m_ready),
    .reload       (reload),
    .reload_valid (reload_valid),
    .reload_ready ()
  );

endmodule

// ==== sim/fir_iq_checker.sv ====
`timescale 1ns/1ps

module fir_iq_checker
  import fir_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input ctrl_resp_t ctrl_resp,
  input logic       s_valid,
  input logic       s_ready,
  input iq_sample_t m_data,
  input logic       m_last,
  input logic       m_valid,
  input logic       m_ready
);

  // Failed assertions, read by the testbench at the end
  int unsigned err_cnt = 0;

  //--------------------------------------------------------------------------
  // Control port
  //--------------------------------------------------------------------------

  // Ack is a single pulse
  ack_pulse: assert property (@(posedge clk) disable iff (rst)
    ctrl_resp.ack |=> !ctrl_resp.ack)
    else begin
      err_cnt++;
      $error("acknowledge high for two cycles in a row");
    end

  // Skip the first edge, flops still unknown there
  reset_quiet: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!m_valid && !ctrl_resp.ack))
    else begin
      err_cnt++;
      $error("m_valid or ack high during reset");
    end

  //--------------------------------------------------------------------------
  // Sample stream
  //--------------------------------------------------------------------------

  // Stalled output holds its payload
  out_stable: assert property (@(posedge clk) disable iff (rst)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)))
    else begin
      err_cnt++;
      $error("output changed or dropped under back-pressure");
    end

  // One register stage
  out_next: assert property (@(posedge clk) disable iff (rst)
    (s_valid && s_ready) |=> m_valid)
    else begin
      err_cnt++;
      $error("accepted sample not followed by m_valid");
    end

endmodule

bind fir_iq_core fir_iq_checker checker_inst (
  .clk       (clk),
  .rst       (rst),
  .ctrl_resp (ctrl_resp),
  .s_valid   (s_valid),
  .s_ready   (s_ready),
  .m_data    (m_data),
  .m_last    (m_last),
  .m_valid   (m_valid),
  .m_ready   (m_ready)
);

// ==== sim/fir_iq_tb.sv ====
`timescale 1ns/1ps

module fir_iq_tb
  import fir_pkg::*;
();

  localparam logic [31:0] SEED      = 32'hc2070ec3;
  localparam string       CASE_FILE = "sim/fir_cases.txt";

  logic       clk;
  logic       rst;
  ctrl_req_t  ctrl_req;
  ctrl_resp_t ctrl_resp;
  iq_sample_t s_data;
  logic       s_last;
  logic       s_valid;
  logic       s_ready;
  iq_sample_t m_data;
  logic       m_last;
  logic       m_valid;
  logic       m_ready;

  // Parsed case file, one entry per keyword
  string op_q [$];
  string name_q [$];
  int    arg_a [$];
  int    arg_b [$];
  int    arg_c [$];

  // Expected {i, q, last} per accepted sample
  logic [2*SAMPLE_W:0] exp_q [$];

  // Model state: active and shadow taps, delay line per channel
  shortint coef_act [NUM_TAPS];
  shortint coef_shd [NUM_TAPS];
  shortint dly [2][NUM_TAPS];

  string       cur_test;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  int          parse_errs;
  int          cycle_cnt;
  int          cycle_limit;
  bit          limit_set;
  logic [31:0] rng;

  fir_iq_core fir_iq_core_inst (
    .clk       (clk),
    .rst       (rst),
    .ctrl_req  (ctrl_req),
    .ctrl_resp (ctrl_resp),
    .s_data    (s_data),
    .s_last    (s_last),
    .s_valid   (s_valid),
    .s_ready   (s_ready),
    .m_data    (m_data),
    .m_last    (m_last),
    .m_valid   (m_valid),
    .m_ready   (m_ready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Watchdog, limit known once the case file is parsed
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit_set && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Shift one sample in, full-precision sum, scale and keep low 16 bits
  function automatic logic [SAMPLE_W-1:0] filter_step(input int ch, input shortint x);
    longint acc;
    acc = 0;
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      dly[ch][k] = dly[ch][k-1];
    end
    dly[ch][0] = x;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc = acc + longint'(coef_act[k]) * longint'(dly[ch][k]);
    end
    acc = acc >>> OUT_SHIFT;
    return acc[SAMPLE_W-1:0];
  endfunction

  //--------------------------------------------------------------------------
  // Case file
  //--------------------------------------------------------------------------

  task automatic load_cases();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    string tok;
    string arg;
    string line;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open case file %s", CASE_FILE);
      parse_errs++;
      return;
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      a   = 0;
      b   = 0;
      c   = 0;
      arg = "";
      if (tok.substr(0, 0) == "#") begin
        // Rest of a comment line
        n = $fgets(line, fd);
      end else begin
        if (tok == "test") begin
          n = $fscanf(fd, "%s", arg);
        end else if (tok == "wr") begin
          n = $fscanf(fd, "%h %h", a, b);
        end else if (tok == "rd") begin
          n = $fscanf(fd, "%h %s", a, arg);
          if (arg == "NOACK") c = 1;
          else n = $sscanf(arg, "%h", b);
        end else if (tok == "smp") begin
          n = $fscanf(fd, "%d %h %d", a, b, c);
        end else if (tok != "end") begin
          $display("Unknown keyword %s in case file", tok);
          parse_errs++;
        end
        op_q.push_back(tok);
        name_q.push_back(arg);
        arg_a.push_back(a);
        arg_b.push_back(b);
        arg_c.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  //--------------------------------------------------------------------------
  // Control port
  //--------------------------------------------------------------------------

  // One strobe, then up to 8 cycles for the acknowledge
  task automatic ctrl_access(input bit is_wr, input logic [CTRL_ADDR_W-1:0] addr,
                             input logic [31:0] wdata, output bit got_ack,
                             output int latency, output logic [31:0] rdata);
    ctrl_req_t req;
    req      = '0;
    req.wr   = is_wr;
    req.rd   = !is_wr;
    req.addr = addr;
    req.data = wdata;
    got_ack  = 1'b0;
    latency  = 0;
    rdata    = '0;
    @(posedge clk);
    ctrl_req <= req;
    @(posedge clk);
    ctrl_req <= '0;
    for (int i = 1; i <= 8 && !got_ack; i++) begin
      @(negedge clk);
      if (ctrl_resp.ack) begin
        got_ack = 1'b1;
        latency = i;
        rdata   = ctrl_resp.data;
      end
    end
  endtask

  task automatic write_coeff(input int off, input logic [31:0] data);
    bit          ack;
    int          lat;
    logic [31:0] rdata;
    ctrl_access(1'b1, (FIR_BASE_ADDR << REG_ADDR_W) | CTRL_ADDR_W'(off), data, ack, lat, rdata);
    assert (ack) else begin
      $display("Test %s: write to offset %0h was never acknowledged", cur_test, off);
      test_errs++;
    end
    if (ack) begin
      assert (rdata == 32'h0) else begin
        $display("Error in %s: expected %h, actual %h", cur_test, 32'h0, rdata);
        test_errs++;
      end
      // Newest value enters at the top of the shadow set
      for (int k = 0; k < NUM_TAPS - 1; k++) begin
        coef_shd[k] = coef_shd[k+1];
      end
      coef_shd[NUM_TAPS-1] = shortint'(data[COEFF_W-1:0]);
      if (off == int'(REG_LOAD_COEFF_LAST)) coef_act = coef_shd;
    end
  endtask

  task automatic read_check(input int addr, input int exp_data, input bit no_ack);
    bit          ack;
    int          lat;
    logic [31:0] rdata;
    ctrl_access(1'b0, addr[CTRL_ADDR_W-1:0], 32'h0, ack, lat, rdata);
    if (no_ack) begin
      assert (!ack) else begin
        $display("Test %s: read of %05h was acknowledged, none expected", cur_test, addr);
        test_errs++;
      end
    end else begin
      assert (ack && lat == 1) else begin
        $display("Test %s: read of %05h not acknowledged one cycle later", cur_test, addr);
        test_errs++;
      end
      if (ack) begin
        assert (rdata == exp_data) else begin
          $display("Error in %s: expected %h, actual %h", cur_test, exp_data, rdata);
          test_errs++;
        end
      end
    end
  endtask

  //--------------------------------------------------------------------------
  // Sample stream
  //--------------------------------------------------------------------------

  // Handshakes observed at the falling edge, transfer at the next rising one
  task automatic run_burst(input int count, input int seed_off, input int last_idx);
    int                  sent;
    int                  recv;
    bit                  in_fire;
    bit                  out_fire;
    logic [2*SAMPLE_W:0] exp;
    logic [2*SAMPLE_W:0] got;
    sent    = 0;
    recv    = 0;
    in_fire = 1'b0;
    rng     = SEED + seed_off;
    @(posedge clk);
    while (recv < count) begin
      if (!s_valid || in_fire) begin
        if (sent < count) begin
          rng = xorshift32(rng);
          s_data  <= rng;
          s_last  <= (sent == last_idx);
          s_valid <= 1'b1;
        end else begin
          s_valid <= 1'b0;
        end
      end
      // Ready about three cycles in four
      rng = xorshift32(rng);
      m_ready <= (rng[1:0] != 2'b00);
      @(negedge clk);
      in_fire  = s_valid && s_ready;
      out_fire = m_valid && m_ready;
      if (out_fire) begin
        got = {m_data, m_last};
        assert (exp_q.size() > 0) else begin
          $display("Test %s: output appeared with no sample in flight", cur_test);
          test_errs++;
        end
        if (exp_q.size() > 0) begin
          exp = exp_q.pop_front();
          assert (got == exp) else begin
            $display("Error in %s: expected %h, actual %h", cur_test, exp, got);
            test_errs++;
          end
        end
        recv++;
      end
      if (in_fire) begin
        exp_q.push_back({filter_step(0, shortint'(s_data.i)),
                         filter_step(1, shortint'(s_data.q)), s_last});
        sent++;
      end
      @(posedge clk);
    end
    m_ready <= 1'b0;
    s_last  <= 1'b0;
  endtask

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    int chk_errs;
    int reqs;
    rst       = 1'b1;
    ctrl_req  = '0;
    s_data    = '0;
    s_last    = 1'b0;
    s_valid   = 1'b0;
    m_ready   = 1'b0;
    cycle_cnt = 0;
    limit_set = 1'b0;
    // Impulse after reset, empty delay lines
    for (int k = 0; k < NUM_TAPS; k++) begin
      coef_act[k] = (k == 0) ? shortint'(32767) : shortint'(0);
      coef_shd[k] = coef_act[k];
      dly[0][k]   = 0;
      dly[1][k]   = 0;
    end
    load_cases();
    reqs = 0;
    for (int i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "wr" || op_q[i] == "rd") reqs = reqs + 1;
      if (op_q[i] == "smp") reqs = reqs + arg_a[i];
    end
    cycle_limit = 200 * reqs + 100;
    limit_set   = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "test") begin
        cur_test  = name_q[i];
        test_errs = 0;
      end else if (op_q[i] == "wr") begin
        write_coeff(arg_a[i], arg_b[i]);
      end else if (op_q[i] == "rd") begin
        read_check(arg_a[i], arg_b[i], arg_c[i] != 0);
      end else if (op_q[i] == "smp") begin
        run_burst(arg_a[i], arg_b[i], arg_c[i]);
      end else if (op_q[i] == "end") begin
        $display("Test %-18s %s (%0d errors)", cur_test,
                 (test_errs == 0) ? "PASS" : "FAIL", test_errs);
        if (test_errs == 0) pass_cnt++;
        else fail_cnt++;
      end
    end
    chk_errs = fir_iq_core_inst.checker_inst.err_cnt;
    $display("Tests passed: %0d, failed: %0d, assertion failures: %0d, case file errors: %0d",
             pass_cnt, fail_cnt, chk_errs, parse_errs);
    if (fail_cnt == 0 && chk_errs == 0 && parse_errs == 0 && pass_cnt > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim/fir_cases.txt ====
# test <name> | wr <offset hex> <data hex> | rd <address hex> <data hex or NOACK> | end
# smp <count> <seed offset hex> <index of last, -1 for none>
test reg_read
rd 00040 00000008
rd 00050 NOACK
rd 0004c NOACK
end
test impulse_default
smp 24 0 23
end
test coeff_reload
wr 4 00001000
wr 4 0000c000
wr 4 00007fff
wr 4 00008000
wr 4 00002000
wr 4 0000f000
wr 4 00007fff
wr 8 00004000
smp 40 11 39
end
test back_pressure
smp 64 22 31
end
test reload_midstream
smp 16 33 -1
wr 4 00007fff
wr 4 00007fff
wr 4 00008000
wr 4 00000100
wr 4 0000ff00
wr 4 00003000
wr 4 00008000
wr 8 00007fff
smp 16 44 15
end

// ==== sources.f ====
design/fir_pkg.sv
design/fir_ctrl_regs.sv
design/fir_coeff_bank.sv
design/fir_channel.sv
design/fir_iq_core.sv
sim/fir_iq_checker.sv
sim/fir_iq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module fir_iq_tb -Mdir obj_dir -f sources.f

./obj_dir/Vfir_iq_tb +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "Run failed, see $LOG"
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "Run ended without a result, see $LOG"
  exit 1
fi
echo "Run passed"
